//--- ex2_wb_top.f
+incdir+.
wb_pkg.sv
div_iterative.sv
ex2_wb_stage.sv
gpr_file.sv
ex2_wb_top.sv
ex2_wb_chk.sv
tb_ex2_wb_top.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ex2_wb_top -f ex2_wb_top.f -o sim_tb \
    > sim.log 2>&1 && ./obj_dir/sim_tb >> sim.log 2>&1
cat sim.log
grep -q '^>>> PASS$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tb_ex2_wb_top.sv
`include "wb_defs.svh"

module tb_ex2_wb_top;

    localparam wb_pkg::uop_t U_DIV = 16'h1 << `UOP_INS_DIV;
    localparam wb_pkg::uop_t U_MEM = 16'h1 << `UOP_INS_MEM;
    localparam wb_pkg::uop_t U_CSR = 16'h1 << `UOP_INS_CSR;
    localparam wb_pkg::uop_t U_ST  = 16'h4 << `UOP_COND_LO;   // store, cond bit 2
    localparam wb_pkg::word_t CSR_VAL = 32'hc5c5_0011;
    localparam wb_pkg::word_t DC_VAL  = 32'hdcdc_2200;

    typedef struct packed {
        logic [95:0]      name;
        logic [1:0]       kind;         // 0 write-back, 1 exception, 2 divide
        wb_pkg::lane_in_t l0;
        wb_pkg::lane_in_t l1;
        logic [2:0]       strb;         // flush_in, csr_ready, dcache_ready
        wb_pkg::exc_in_t  exc;
        logic             ie;
        logic [12:0]      estat;
        wb_pkg::ridx_t    ra0;
        wb_pkg::ridx_t    ra1;
        wb_pkg::word_t    e_rd0;
        wb_pkg::word_t    e_rd1;
        wb_pkg::wb_port_t e_wb0;
        wb_pkg::wb_port_t e_wb1;
        logic [3:0]       e_exc;        // flag, wen_badv, wen_vppn, tlb_refill
        wb_pkg::ecode_t   e_ecode;
        logic             div_signed;
        wb_pkg::word_t    div_a;
        wb_pkg::word_t    div_b;
    } vec_t;

    logic clk = 1'b0;
    logic aresetn;
    wb_pkg::lane_in_t lane0;
    wb_pkg::lane_in_t lane1;
    wb_pkg::div_req_t div_req;
    wb_pkg::word_t    dcache_data;
    wb_pkg::word_t    csr_data;
    wb_pkg::word_t    csr_crmd;
    wb_pkg::word_t    csr_estat;
    logic             dcache_ready;
    logic             csr_ready;
    logic             flush_in;
    logic             ex2_allowin;
    logic             flush_out;
    wb_pkg::exc_in_t  exc_in;
    wb_pkg::ridx_t    raddr0;
    wb_pkg::ridx_t    raddr1;
    wb_pkg::wb_port_t wb0;
    wb_pkg::wb_port_t wb1;
    wb_pkg::trace_t   trace0;
    wb_pkg::trace_t   trace1;
    wb_pkg::exc_out_t exc_out;
    wb_pkg::word_t    rdata0;
    wb_pkg::word_t    rdata1;

    vec_t tab[$];
    int   cycles = 0;
    int   max_cycles = 100;

    ex2_wb_top u_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            abort_run($sformatf("timeout after %0d cycles", cycles));
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input logic [95:0] name, input string what,
                         input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            abort_run($sformatf("[FAIL] %s %s expected %h actual %h", name, what, exp, act));
        end
    endtask

    function automatic wb_pkg::lane_in_t lane(wb_pkg::uop_t uop, wb_pkg::ridx_t rd,
                                              wb_pkg::word_t res, logic rv);
        wb_pkg::lane_in_t l;
        l.pc           = 32'h1c00_0000 + 32'(rd) * 4;
        l.inst         = res ^ 32'h0280_0000;
        l.uop          = uop;
        l.rd           = rd;
        l.result       = res;
        l.result_valid = rv;
        return l;
    endfunction

    function automatic wb_pkg::wb_port_t port(logic we, wb_pkg::ridx_t rd, wb_pkg::word_t d);
        wb_pkg::wb_port_t p;
        p.we   = we;
        p.rd   = rd;
        p.data = d;
        return p;
    endfunction

    task automatic add_wb(input logic [95:0] name, input wb_pkg::lane_in_t l0,
                          input wb_pkg::lane_in_t l1, input logic [2:0] strb,
                          input wb_pkg::ridx_t ra0, input wb_pkg::ridx_t ra1,
                          input wb_pkg::word_t e_rd0, input wb_pkg::word_t e_rd1,
                          input wb_pkg::wb_port_t e_wb0, input wb_pkg::wb_port_t e_wb1);
        vec_t v;
        v = '0;
        v.name  = name;
        v.l0    = l0;
        v.l1    = l1;
        v.strb  = strb;
        v.ra0   = ra0;
        v.ra1   = ra1;
        v.e_rd0 = e_rd0;
        v.e_rd1 = e_rd1;
        v.e_wb0 = e_wb0;
        v.e_wb1 = e_wb1;
        tab.push_back(v);
    endtask

    task automatic add_exc(input logic [95:0] name, input logic flag, input wb_pkg::ecode_t code,
                           input wb_pkg::word_t badv, input logic ie, input logic [12:0] estat,
                           input logic [3:0] e_exc, input wb_pkg::ecode_t e_ecode);
        vec_t v;
        v = '0;
        v.name     = name;
        v.kind     = 2'd1;
        v.exc.flag = flag;
        v.exc.ecode = code;
        v.exc.badv = badv;
        v.exc.era  = 32'h1c00_0400;
        v.ie       = ie;
        v.estat    = estat;
        v.e_exc    = e_exc;
        v.e_ecode  = e_ecode;
        tab.push_back(v);
    endtask

    task automatic add_div(input logic [95:0] name, input logic sgn, input logic zero,
                           input logic cond0);
        vec_t v;
        v = '0;
        v.name       = name;
        v.kind       = 2'd2;
        v.l0         = lane(U_DIV | {15'h0, cond0}, 5'd10, '0, 1'b0);
        v.div_signed = sgn;
        v.div_a      = $urandom();
        v.div_b      = zero ? '0 : $urandom();
        if (sgn && v.div_a == 32'h8000_0000 && v.div_b == '1) begin
            v.div_b = 32'd1;    // avoid the one overflowing signed case
        end
        tab.push_back(v);
    endtask

    function automatic wb_pkg::word_t div_expect(vec_t v);
        wb_pkg::word_t q;
        wb_pkg::word_t r;
        if (v.div_b == '0) begin
            q = '1;
            r = v.div_a;
        end else if (v.div_signed) begin
            q = $unsigned($signed(v.div_a) / $signed(v.div_b));
            r = $unsigned($signed(v.div_a) % $signed(v.div_b));
        end else begin
            q = v.div_a / v.div_b;
            r = v.div_a % v.div_b;
        end
        return v.l0.uop[`UOP_COND_LO] ? r : q;
    endfunction

    task automatic drive(input vec_t v);
        lane0        = v.l0;
        lane1        = v.l1;
        dcache_ready = v.strb[0];
        csr_ready    = v.strb[1];
        flush_in     = v.strb[2];
        exc_in       = v.exc;
        csr_crmd     = 32'(v.ie) << `CRMD_IE_BIT;
        csr_estat    = {19'h0, v.estat};
        raddr0       = v.ra0;
        raddr1       = v.ra1;
    endtask

    task automatic run_divide(input vec_t v);
        int waited;
        waited = 0;
        drive(v);
        div_req.start     = 1'b1;
        div_req.is_signed = v.div_signed;
        div_req.dividend  = v.div_a;
        div_req.divisor   = v.div_b;
        @(negedge clk);
        div_req.start = 1'b0;
        while (!u_dut.div_ready) begin
            check(v.name, "early we", 64'(1'b0), 64'(wb0.we));
            check(v.name, "allowin busy", 64'(1'b0), 64'(ex2_allowin));
            @(negedge clk);
            waited++;
            if (waited > 40) begin
                abort_run("divider never raised div_ready");
            end
        end
        check(v.name, "we at ready", 64'(1'b0), 64'(wb0.we));
        check(v.name, "allowin ready", 64'(1'b1), 64'(ex2_allowin));
        @(negedge clk);
        check(v.name, "wb0", 64'(port(1'b1, 5'd10, div_expect(v))), 64'(wb0));
    endtask

    task automatic run_entry(input vec_t v);
        logic exp_allow;
        drive(v);
        exp_allow = (v.l0.result_valid & v.l1.result_valid) | v.strb[0] | v.strb[1];
        #1;
        check(v.name, "allowin", 64'(exp_allow), 64'(ex2_allowin));
        @(negedge clk);
        check(v.name, "wb0", 64'(v.e_wb0), 64'(wb0));
        check(v.name, "wb1", 64'(v.e_wb1), 64'(wb1));
        check(v.name, "trace0 pc inst", {v.l0.pc, v.l0.inst}, {trace0.pc, trace0.inst});
        check(v.name, "trace0 port", 64'({{4{v.e_wb0.we}}, v.e_wb0.rd, v.e_wb0.data}),
              64'({trace0.rf_wen, trace0.rf_wnum, trace0.rf_wdata}));
        check(v.name, "trace1 pc inst", {v.l1.pc, v.l1.inst}, {trace1.pc, trace1.inst});
        check(v.name, "trace1 port", 64'({{4{v.e_wb1.we}}, v.e_wb1.rd, v.e_wb1.data}),
              64'({trace1.rf_wen, trace1.rf_wnum, trace1.rf_wdata}));
        check(v.name, "rdata0", 64'(v.e_rd0), 64'(rdata0));
        check(v.name, "rdata1", 64'(v.e_rd1), 64'(rdata1));
        check(v.name, "exc flags", 64'(v.e_exc),
              64'({exc_out.flag, exc_out.wen_badv, exc_out.wen_vppn, exc_out.tlb_refill}));
        check(v.name, "wen_era", 64'(v.e_exc[3]), 64'(exc_out.wen_era));
        check(v.name, "badv era", {v.exc.badv, v.exc.era}, {exc_out.badv, exc_out.era});
        check(v.name, "flush_out", 64'(v.e_exc[3]), 64'(flush_out));
        if (v.e_exc[3]) begin
            check(v.name, "ecode", 64'(v.e_ecode), 64'(exc_out.ecode));
            check(v.name, "vppn", 64'(v.exc.badv[18:0]), 64'(exc_out.vppn));
        end
    endtask

    initial begin
        void'($urandom(32'hec4f_5072));
        aresetn = 1'b0;
        drive('0);
        div_req     = '0;
        dcache_data = DC_VAL;
        csr_data    = CSR_VAL;

        add_wb("alu_pair", lane('0, 5'd3, 32'h1111_0003, 1'b1), lane('0, 5'd5, 32'h2222_0005, 1'b1),
               3'b000, 5'd0, 5'd0, '0, '0, port(1'b1, 5'd3, 32'h1111_0003),
               port(1'b1, 5'd5, 32'h2222_0005));
        add_wb("same_rd", lane('0, 5'd7, 32'h3333_0007, 1'b1), lane('0, 5'd7, 32'h4444_0007, 1'b1),
               3'b000, 5'd3, 5'd5, 32'h1111_0003, 32'h2222_0005,
               port(1'b1, 5'd7, 32'h3333_0007), port(1'b1, 5'd7, 32'h4444_0007));
        add_wb("lane1_wins", '0, '0, 3'b000, 5'd7, 5'd0, 32'h4444_0007, '0, '0, '0);
        add_wb("r0_write", lane('0, 5'd0, 32'h5555_0000, 1'b1), '0, 3'b000, 5'd0, 5'd3,
               '0, 32'h1111_0003, port(1'b1, 5'd0, 32'h5555_0000), '0);
        add_wb("r0_read", '0, '0, 3'b000, 5'd0, 5'd0, '0, '0, '0, '0);
        add_wb("priority", lane(U_DIV | U_MEM | U_CSR, 5'd8, 32'h6666_0008, 1'b1),
               lane(U_DIV | U_MEM | U_CSR, 5'd9, 32'h7777_0009, 1'b1), 3'b011, 5'd0, 5'd0,
               '0, '0, port(1'b1, 5'd8, 32'h6666_0008), port(1'b1, 5'd9, 32'h7777_0009));
        add_wb("csr_lane0", lane(U_CSR, 5'd11, '0, 1'b0), lane(U_CSR, 5'd12, '0, 1'b0), 3'b010,
               5'd8, 5'd9, 32'h6666_0008, 32'h7777_0009, port(1'b1, 5'd11, CSR_VAL), '0);
        add_wb("load_ready", lane(U_MEM, 5'd13, '0, 1'b0), lane(U_MEM, 5'd14, '0, 1'b0), 3'b001,
               5'd11, 5'd12, CSR_VAL, '0, port(1'b1, 5'd13, DC_VAL), port(1'b1, 5'd14, DC_VAL));
        add_wb("load_wait", lane(U_MEM, 5'd13, '0, 1'b0), '0, 3'b000, 5'd13, 5'd14,
               DC_VAL, DC_VAL, port(1'b0, 5'd13, DC_VAL), '0);
        add_wb("store", lane(U_MEM | U_ST, 5'd15, '0, 1'b0), '0, 3'b001, 5'd15, 5'd0,
               '0, '0, '0, '0);
        add_wb("flush", lane('0, 5'd16, 32'h8888_0010, 1'b1), lane('0, 5'd17, 32'h9999_0011, 1'b1),
               3'b100, 5'd0, 5'd0, '0, '0, port(1'b0, 5'd16, 32'h8888_0010),
               port(1'b0, 5'd17, 32'h9999_0011));
        add_wb("after_flush", '0, '0, 3'b000, 5'd16, 5'd17, '0, '0, '0, '0);
        add_exc("exc_adef", 1'b1, `EXP_ADEF, 32'h8000_1234, 1'b0, '0, 4'b1100, `EXP_ADEF);
        add_exc("exc_pil", 1'b1, `EXP_PIL, 32'h0012_3ff8, 1'b0, '0, 4'b1110, `EXP_PIL);
        add_exc("exc_tlbr", 1'b1, `EXP_TLBR, 32'hdead_b000, 1'b0, '0, 4'b1111, `EXP_TLBR);
        add_exc("exc_sys", 1'b1, `EXP_SYS, 32'h0000_0000, 1'b0, '0, 4'b1000, `EXP_SYS);
        add_exc("int_on", 1'b0, '0, '0, 1'b1, 13'h0008, 4'b1000, `EXP_INT);
        add_exc("int_off", 1'b0, '0, '0, 1'b0, 13'h0008, 4'b0000, `EXP_INT);
        add_div("div_u_quo", 1'b0, 1'b0, 1'b0);
        add_div("div_s_rem", 1'b1, 1'b0, 1'b1);
        add_div("div_s_quo", 1'b1, 1'b0, 1'b0);
        add_div("div_zero_q", 1'b0, 1'b1, 1'b0);
        add_div("div_zero_r", 1'b1, 1'b1, 1'b1);
        max_cycles = 40 * tab.size() + 100;

        repeat (3) @(negedge clk);
        aresetn = 1'b1;
        @(negedge clk);
        foreach (tab[i]) begin
            if (tab[i].kind == 2'd2) begin
                run_divide(tab[i]);
            end else begin
                run_entry(tab[i]);
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- ex2_wb_chk.sv
module ex2_wb_chk (
    input logic             clk,
    input logic             aresetn,
    input logic             flush_in,
    input wb_pkg::wb_port_t wb0,
    input wb_pkg::wb_port_t wb1,
    input wb_pkg::exc_out_t exc_out,
    input wb_pkg::word_t    r0_val
);

    // flushed cycle leaves both ports idle
    no_we_after_flush: assert property (
        @(posedge clk) disable iff (!aresetn)
        $past(flush_in) |-> (!wb0.we && !wb1.we)
    ) else $error("write enable set after flush");

    vppn_needs_badv: assert property (
        @(posedge clk) disable iff (!aresetn)
        exc_out.wen_vppn |-> exc_out.wen_badv
    ) else $error("wen_vppn without wen_badv");

    // a write aimed at r0 must not land
    r0_stays_zero: assert property (
        @(posedge clk) disable iff (!aresetn)
        ((wb0.we && wb0.rd == '0) || (wb1.we && wb1.rd == '0)) |=> (r0_val == '0)
    ) else $error("r0 changed after write to rd zero");

endmodule

bind ex2_wb_top ex2_wb_chk u_chk (
    .clk      (clk),
    .aresetn  (aresetn),
    .flush_in (flush_in),
    .wb0      (wb0),
    .wb1      (wb1),
    .exc_out  (exc_out),
    .r0_val   (u_gpr.regs[0])
);

//--- ex2_wb_top.sv
module ex2_wb_top (
    input  logic             clk,
    input  logic             aresetn,
    input  wb_pkg::lane_in_t lane0,
    input  wb_pkg::lane_in_t lane1,
    input  wb_pkg::div_req_t div_req,
    input  wb_pkg::word_t    dcache_data,
    input  logic             dcache_ready,
    input  wb_pkg::word_t    csr_data,
    input  logic             csr_ready,
    input  wb_pkg::exc_in_t  exc_in,
    input  wb_pkg::word_t    csr_crmd,
    input  wb_pkg::word_t    csr_estat,
    input  logic             flush_in,
    input  wb_pkg::ridx_t    raddr0,
    input  wb_pkg::ridx_t    raddr1,
    output logic             ex2_allowin,
    output wb_pkg::wb_port_t wb0,
    output wb_pkg::wb_port_t wb1,
    output wb_pkg::trace_t   trace0,
    output wb_pkg::trace_t   trace1,
    output wb_pkg::exc_out_t exc_out,
    output logic             flush_out,
    output wb_pkg::word_t    rdata0,
    output wb_pkg::word_t    rdata1
);

    wb_pkg::word_t quotient;
    wb_pkg::word_t remainder;
    logic          div_ready;

    div_iterative u_div (
        .clk       (clk),
        .aresetn   (aresetn),
        .req       (div_req),
        .quotient  (quotient),
        .remainder (remainder),
        .div_ready (div_ready),
        .busy      ()             // requester tracks its own start
    );

    ex2_wb_stage u_stage (
        .clk          (clk),
        .aresetn      (aresetn),
        .flush_in     (flush_in),
        .lane0        (lane0),
        .lane1        (lane1),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_ready    (div_ready),
        .dcache_data  (dcache_data),
        .dcache_ready (dcache_ready),
        .csr_data     (csr_data),
        .csr_ready    (csr_ready),
        .exc_in       (exc_in),
        .csr_crmd     (csr_crmd),
        .csr_estat    (csr_estat),
        .ex2_allowin  (ex2_allowin),
        .wb0          (wb0),
        .wb1          (wb1),
        .trace0       (trace0),
        .trace1       (trace1),
        .exc_out      (exc_out),
        .flush_out    (flush_out)
    );

    gpr_file u_gpr (
        .clk     (clk),
        .aresetn (aresetn),
        .wb0     (wb0),
        .wb1     (wb1),
        .raddr0  (raddr0),
        .raddr1  (raddr1),
        .rdata0  (rdata0),
        .rdata1  (rdata1)
    );

endmodule

//--- gpr_file.sv
module gpr_file (
    input  logic             clk,
    input  logic             aresetn,
    input  wb_pkg::wb_port_t wb0,
    input  wb_pkg::wb_port_t wb1,
    input  wb_pkg::ridx_t    raddr0,
    input  wb_pkg::ridx_t    raddr1,
    output wb_pkg::word_t    rdata0,
    output wb_pkg::word_t    rdata1
);

    wb_pkg::word_t regs [32];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0.we && wb0.rd != '0) begin
                regs[wb0.rd] <= wb0.data;
            end
            // later assignment, lane 1 wins on same rd
            if (wb1.we && wb1.rd != '0) begin
                regs[wb1.rd] <= wb1.data;
            end
        end
    end

    assign rdata0 = regs[raddr0];   // r0 never written
    assign rdata1 = regs[raddr1];

endmodule

//--- ex2_wb_stage.sv
`include "wb_defs.svh"

module ex2_wb_stage (
    input  logic             clk,
    input  logic             aresetn,
    input  logic             flush_in,
    input  wb_pkg::lane_in_t lane0,
    input  wb_pkg::lane_in_t lane1,
    input  wb_pkg::word_t    quotient,
    input  wb_pkg::word_t    remainder,
    input  logic             div_ready,
    input  wb_pkg::word_t    dcache_data,
    input  logic             dcache_ready,
    input  wb_pkg::word_t    csr_data,
    input  logic             csr_ready,
    input  wb_pkg::exc_in_t  exc_in,
    input  wb_pkg::word_t    csr_crmd,
    input  wb_pkg::word_t    csr_estat,
    output logic             ex2_allowin,
    output wb_pkg::wb_port_t wb0,
    output wb_pkg::wb_port_t wb1,
    output wb_pkg::trace_t   trace0,
    output wb_pkg::trace_t   trace1,
    output wb_pkg::exc_out_t exc_out,
    output logic             flush_out
);

    wb_pkg::wb_port_t sel0;
    wb_pkg::wb_port_t sel1;
    wb_pkg::word_t    pc0_q;
    wb_pkg::word_t    pc1_q;
    wb_pkg::word_t    inst0_q;
    wb_pkg::word_t    inst1_q;
    logic             int_pending;
    logic             take_exc;
    logic             addr_code;
    logic             tlb_code;

    // priority: alu result, csr, div, load
    function automatic wb_pkg::wb_port_t pick_source(
        input wb_pkg::lane_in_t lane,
        input logic             csr_en
    );
        wb_pkg::wb_port_t            p;
        logic [`UOP_COND_W-1:0]      cond;
        p    = '0;
        cond = lane.uop[`UOP_COND_LO +: `UOP_COND_W];
        if (lane.result_valid) begin
            p.we   = 1'b1;
            p.rd   = lane.rd;
            p.data = lane.result;
        end else if (csr_en && lane.uop[`UOP_INS_CSR]) begin
            p.we   = csr_ready;
            p.rd   = lane.rd;
            p.data = csr_data;
        end else if (lane.uop[`UOP_INS_DIV]) begin
            p.we   = div_ready;
            p.rd   = lane.rd;
            p.data = cond[0] ? remainder : quotient;
        end else if (lane.uop[`UOP_INS_MEM] && !cond[2]) begin  // stores write nothing
            p.we   = dcache_ready;
            p.rd   = lane.rd;
            p.data = dcache_data;
        end
        return p;
    endfunction

    always_comb begin
        sel0 = pick_source(lane0, 1'b1);
        sel1 = pick_source(lane1, 1'b0);   // no csr port on lane 1
    end

    assign ex2_allowin = (lane0.result_valid & lane1.result_valid)
                       | dcache_ready | div_ready | csr_ready;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            wb0 <= '0;
            wb1 <= '0;
        end else begin
            wb0    <= sel0;
            wb1    <= sel1;
            wb0.we <= sel0.we & ~flush_in;
            wb1.we <= sel1.we & ~flush_in;
        end
    end

    always_ff @(posedge clk) begin
        pc0_q   <= lane0.pc;
        pc1_q   <= lane1.pc;
        inst0_q <= lane0.inst;
        inst1_q <= lane1.inst;
    end

    // trace follows the registered port
    assign trace0 = '{pc:       pc0_q,
                      inst:     inst0_q,
                      rf_wen:   {4{wb0.we}},
                      rf_wnum:  wb0.rd,
                      rf_wdata: wb0.data};
    assign trace1 = '{pc:       pc1_q,
                      inst:     inst1_q,
                      rf_wen:   {4{wb1.we}},
                      rf_wnum:  wb1.rd,
                      rf_wdata: wb1.data};

    assign int_pending = csr_crmd[`CRMD_IE_BIT] & (|csr_estat[`ESTAT_IS_W-1:0]);
    assign take_exc    = exc_in.flag | int_pending;

    assign tlb_code = (exc_in.ecode == `EXP_PIL) || (exc_in.ecode == `EXP_PIS)
                   || (exc_in.ecode == `EXP_PIF) || (exc_in.ecode == `EXP_PME)
                   || (exc_in.ecode == `EXP_PPI) || (exc_in.ecode == `EXP_TLBR);
    assign addr_code = tlb_code || (exc_in.ecode == `EXP_ADEF)
                    || (exc_in.ecode == `EXP_ALE);

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            exc_out <= '0;
        end else begin
            exc_out.flag       <= take_exc;
            // interrupt alone reports EXP_INT
            exc_out.ecode      <= exc_in.flag ? exc_in.ecode
                                : (int_pending ? `EXP_INT : exc_in.ecode);
            exc_out.badv       <= exc_in.badv;
            exc_out.wen_badv   <= exc_in.flag & addr_code;
            exc_out.era        <= exc_in.era;
            exc_out.wen_era    <= take_exc;
            exc_out.vppn       <= exc_in.badv[18:0];
            exc_out.wen_vppn   <= exc_in.flag & tlb_code;
            exc_out.tlb_refill <= exc_in.flag & (exc_in.ecode == `EXP_TLBR);
        end
    end

    assign flush_out = exc_out.flag;

endmodule

//--- div_iterative.sv
module div_iterative (
    input  logic             clk,
    input  logic             aresetn,
    input  wb_pkg::div_req_t req,
    output wb_pkg::word_t    quotient,
    output wb_pkg::word_t    remainder,
    output logic             div_ready,
    output logic             busy
);

    logic          busy_q;
    logic [5:0]    cnt_q;
    wb_pkg::word_t rem_q;       // partial remainder
    wb_pkg::word_t quo_q;       // dividend bits out, quotient bits in
    wb_pkg::word_t dvs_q;       // divisor magnitude
    logic          neg_quo_q;
    logic          neg_rem_q;
    logic          dz_q;

    logic          a_neg;
    logic          b_neg;
    wb_pkg::word_t a_mag;
    wb_pkg::word_t b_mag;

    logic [32:0]   shifted;
    logic [32:0]   trial;
    logic          fits;
    wb_pkg::word_t rem_next;
    wb_pkg::word_t quo_next;

    assign a_neg = req.is_signed & req.dividend[31];
    assign b_neg = req.is_signed & req.divisor[31];
    assign a_mag = a_neg ? -req.dividend : req.dividend;
    assign b_mag = b_neg ? -req.divisor : req.divisor;

    // one restoring step
    assign shifted  = {rem_q, quo_q[31]};
    assign trial    = shifted - {1'b0, dvs_q};
    // on divide by zero never subtract, so rem ends up holding |dividend|
    assign fits     = (shifted >= {1'b0, dvs_q}) & ~dz_q;
    assign rem_next = fits ? trial[31:0] : shifted[31:0];
    assign quo_next = {quo_q[30:0], fits};

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            div_ready <= 1'b0;
        end else begin
            div_ready <= 1'b0;
            if (!busy_q) begin
                if (req.start) begin
                    busy_q <= 1'b1;
                    cnt_q  <= 6'd32;
                end
            end else begin
                cnt_q <= cnt_q - 6'd1;
                if (cnt_q == 6'd1) begin
                    busy_q    <= 1'b0;
                    div_ready <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && req.start) begin
            rem_q     <= '0;
            quo_q     <= a_mag;
            dvs_q     <= b_mag;
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;
            dz_q      <= (req.divisor == '0);
        end else if (busy_q) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
            if (cnt_q == 6'd1) begin   // last step, sign fix-up
                quotient  <= dz_q ? '1 : (neg_quo_q ? -quo_next : quo_next);
                remainder <= neg_rem_q ? -rem_next : rem_next;
            end
        end
    end

    assign busy = busy_q;

endmodule

//--- wb_pkg.sv
package wb_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  ridx_t;
    typedef logic [15:0] uop_t;
    typedef logic [6:0]  ecode_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
        uop_t  uop;
        ridx_t rd;
        word_t result;
        logic  result_valid;        // plain alu result present
    } lane_in_t;

    typedef struct packed {
        logic  we;
        ridx_t rd;
        word_t data;
    } wb_port_t;

    typedef struct packed {
        word_t      pc;
        word_t      inst;
        logic [3:0] rf_wen;
        ridx_t      rf_wnum;
        word_t      rf_wdata;
    } trace_t;

    typedef struct packed {
        logic   flag;
        ecode_t ecode;
        word_t  badv;
        word_t  era;
    } exc_in_t;

    typedef struct packed {
        logic        flag;
        ecode_t      ecode;
        word_t       badv;
        logic        wen_badv;
        word_t       era;
        logic        wen_era;
        logic [18:0] vppn;
        logic        wen_vppn;
        logic        tlb_refill;    // back to direct translation
    } exc_out_t;

    typedef struct packed {
        logic  start;
        logic  is_signed;
        word_t dividend;
        word_t divisor;
    } div_req_t;

endpackage

//--- wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// datapath widths
`define WB_XLEN      32
`define WB_RIDX_W    5
`define WB_UOP_W     16

// micro-op flag positions
`define UOP_INS_DIV  4
`define UOP_INS_MEM  5
`define UOP_INS_CSR  6

// cond field is uop[UOP_COND_LO +: 4]
`define UOP_COND_LO  0
`define UOP_COND_W   4

// csr fields used for the interrupt check
`define CRMD_IE_BIT  2
`define ESTAT_IS_W   13

// exception codes
`define EXP_INT      7'h00
`define EXP_PIL      7'h01
`define EXP_PIS      7'h02
`define EXP_PIF      7'h03
`define EXP_PME      7'h04
`define EXP_PPI      7'h07
`define EXP_ADEF     7'h08
`define EXP_ALE      7'h09
`define EXP_SYS      7'h0b
`define EXP_TLBR     7'h3f

`endif
